/* include/fe_consts.svh */
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// nop encoding, andi r0, r0, 0
`define INST_NOP 32'h0340_0000

// first fetch address out of reset
`define PC_RESET 32'h1c00_0000

// instruction queue entries, keep it a power of two
`define IQ_DEPTH 8

// instructions carried per fetch packet
`define ISSUE_WIDTH 2

`endif

/* source/fe_pkg.sv */
package fe_pkg;

    // why the front end is being flushed, not decoded by anything yet
    typedef enum logic [1:0] {
        none,
        branch,
        excp,
        ertn
    } flush_cause_e;

    // one fetch packet, two instructions wide
    typedef struct packed {
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [31:0] pc;          // pc of inst0
        logic [31:0] pc_add;      // pc of inst1
        logic [31:0] pc_next;     // where fetch went after this packet
        logic        pc_taken;    // predicted taken
        logic [31:0] badv;        // faulting address if any
        logic [6:0]  exception;
        logic [1:0]  excp_flag;
        logic [1:0]  priv_flag;
        logic [1:0]  branch_flag;
    } fetch_pkt_t;

endpackage

/* source/dec_pkg.sv */
package dec_pkg;

    // decoded operation class
    typedef enum logic [2:0] {
        op_nop,
        op_alu_rr,
        op_alu_ri,
        op_load,
        op_store,
        op_branch,
        op_invalid
    } opcode_e;

    // result of one slot decoder
    typedef struct packed {
        opcode_e     op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;        // sign-extended
        logic        use_rj;
        logic        use_rk;
        logic        writes_rd;
    } dec_slot_t;

    // what the issue side sees each cycle
    typedef struct packed {
        dec_slot_t   slot0;
        dec_slot_t   slot1;
        logic [31:0] pc;
        logic        pair_ok;    // slot1 may go together with slot0
        logic [6:0]  exception;
        logic [1:0]  excp_flag;
    } issue_bundle_t;

endpackage

/* source/inst_queue.sv */
`timescale 1ns/1ns
`include "fe_consts.svh"

module inst_queue
    import fe_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       flush,

    input  logic       fetch_valid,
    input  fetch_pkt_t fetch_pkt,
    output logic       fetch_ready,

    output logic       q_valid,
    output fetch_pkt_t q_pkt,
    input  logic       q_ready
);

    localparam int depth = `IQ_DEPTH;
    localparam int aw    = $clog2(depth);

    fetch_pkt_t mem [depth];

    // one extra bit on each pointer tells full from empty
    logic [aw:0] wr_ptr;
    logic [aw:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        push;
    logic        pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[aw] != rd_ptr[aw]) &&
                   (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

    assign fetch_ready = !full;
    assign q_valid     = !empty;
    assign q_pkt       = mem[rd_ptr[aw-1:0]];   // head, no read latency

    assign push = fetch_valid && fetch_ready;
    assign pop  = q_valid && q_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            // drop everything queued, a write on this edge is lost too
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // storage, contents only matter between the pointers
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr[aw-1:0]] <= fetch_pkt;
    end

endmodule

/* source/fifo_id_stage.sv */
`timescale 1ns/1ns
`include "fe_consts.svh"

module fifo_id_stage
    import fe_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         flush,
    input  flush_cause_e flush_cause,   // reserved, nothing reads it yet

    input  logic         q_valid,
    input  fetch_pkt_t   q_pkt,
    input  logic         id_allowin,
    output logic         q_ready,

    output logic         stage_valid,
    output fetch_pkt_t   stage_pkt
);

    // empty slot: two nops sitting at the reset pc
    localparam fetch_pkt_t nop_pkt = '{
        inst0:   `INST_NOP,
        inst1:   `INST_NOP,
        pc:      `PC_RESET,
        pc_add:  `PC_RESET + 32'd4,
        pc_next: `PC_RESET + 32'd8,
        badv:    `PC_RESET,
        default: '0
    };

    logic drain;
    logic accept;

    assign q_ready = id_allowin;            // ready whenever decode takes a packet

    // decode consumed our packet and nothing waits behind it
    assign drain  = !q_valid && id_allowin && stage_valid;
    assign accept = q_valid && q_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= 1'b0;
            stage_pkt   <= nop_pkt;
        end else if (flush || drain) begin
            stage_valid <= 1'b0;
            stage_pkt   <= nop_pkt;
        end else if (accept) begin
            stage_valid <= 1'b1;
            stage_pkt   <= q_pkt;
        end
        // stalled, hold
    end

endmodule

/* source/slot_decoder.sv */
`timescale 1ns/1ns
`include "fe_consts.svh"

module slot_decoder
    import dec_pkg::*;
(
    input  logic [31:0] inst,
    output dec_slot_t   slot
);

    logic [5:0] major;

    assign major = inst[31:26];

    always_comb begin
        // fields sit at fixed positions for every format
        slot.rd        = inst[4:0];
        slot.rj        = inst[9:5];
        slot.rk        = inst[14:10];
        slot.imm       = {{20{inst[21]}}, inst[21:10]};
        slot.op        = op_invalid;
        slot.use_rj    = 1'b0;
        slot.use_rk    = 1'b0;
        slot.writes_rd = 1'b0;

        if (inst == `INST_NOP) begin
            slot.op = op_nop;           // full-word match, checked first
        end else begin
            case (major)
                6'b000001: begin        // reg-reg alu
                    slot.op        = op_alu_rr;
                    slot.use_rj    = 1'b1;
                    slot.use_rk    = 1'b1;
                    slot.writes_rd = 1'b1;
                end
                6'b000010: begin        // reg-imm alu
                    slot.op        = op_alu_ri;
                    slot.use_rj    = 1'b1;
                    slot.writes_rd = 1'b1;
                end
                6'b000011: begin
                    slot.op        = op_load;   // base in rj
                    slot.use_rj    = 1'b1;
                    slot.writes_rd = 1'b1;
                end
                6'b000100: begin
                    // store data comes from rd, base from rj
                    slot.op        = op_store;
                    slot.use_rj    = 1'b1;
                end
                6'b000101: begin
                    slot.op        = op_branch; // compares rj with rk
                    slot.use_rj    = 1'b1;
                    slot.use_rk    = 1'b1;
                end
                default: begin
                    slot.op = op_invalid;
                end
            endcase
        end
    end

endmodule

/* source/id_bundle.sv */
`timescale 1ns/1ns
`include "fe_consts.svh"

module id_bundle
    import fe_pkg::*;
    import dec_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          flush,

    input  logic          stage_valid,
    input  fetch_pkt_t    stage_pkt,
    input  dec_slot_t     slots [`ISSUE_WIDTH],

    input  logic          id_allowin,
    output logic          id_valid,
    output issue_bundle_t id_bundle
);

    localparam dec_slot_t slot_clear = '{
        op: op_nop, rd: 5'd0, rj: 5'd0, rk: 5'd0, imm: 32'd0,
        use_rj: 1'b0, use_rk: 1'b0, writes_rd: 1'b0
    };

    localparam issue_bundle_t bundle_clear = '{
        slot0: slot_clear, slot1: slot_clear, pc: `PC_RESET,
        pair_ok: 1'b0, exception: 7'd0, excp_flag: 2'd0
    };

    logic          s0_wr;       // slot0 writes a real register
    logic          raw;
    logic          waw;
    logic          s0_ends;     // slot0 stops pairing by itself
    issue_bundle_t merged;

    assign s0_wr = slots[0].writes_rd && (slots[0].rd != 5'd0);

    assign raw = s0_wr &&
                 ((slots[1].use_rj && (slots[1].rj == slots[0].rd)) ||
                  (slots[1].use_rk && (slots[1].rk == slots[0].rd)));

    assign waw = s0_wr && slots[1].writes_rd && (slots[1].rd == slots[0].rd);

    assign s0_ends = (slots[0].op == op_branch) || (slots[0].op == op_invalid);

    always_comb begin
        merged.slot0     = slots[0];
        merged.slot1     = slots[1];
        merged.pc        = stage_pkt.pc;
        merged.pair_ok   = !(s0_ends || raw || waw);
        merged.exception = stage_pkt.exception;
        merged.excp_flag = stage_pkt.excp_flag;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_valid  <= 1'b0;
            id_bundle <= bundle_clear;
        end else if (flush) begin
            id_valid  <= 1'b0;
            id_bundle <= bundle_clear;
        end else if (id_allowin) begin
            id_valid  <= stage_valid;   // one edge behind the stage
            id_bundle <= merged;
        end
    end

endmodule

/* source/frontend_top.sv */
`timescale 1ns/1ns
`include "fe_consts.svh"

module frontend_top
    import fe_pkg::*;
    import dec_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          flush,
    input  flush_cause_e  flush_cause,

    input  logic          fetch_valid,
    input  fetch_pkt_t    fetch_pkt,
    output logic          fetch_ready,

    input  logic          id_allowin,
    output logic          id_valid,
    output issue_bundle_t id_bundle
);

    logic       q_valid;
    logic       q_ready;
    fetch_pkt_t q_pkt;
    logic       stage_valid;
    fetch_pkt_t stage_pkt;
    dec_slot_t  dec_slots [`ISSUE_WIDTH];

    inst_queue u_queue (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_pkt   (fetch_pkt),
        .fetch_ready (fetch_ready),
        .q_valid     (q_valid),
        .q_pkt       (q_pkt),
        .q_ready     (q_ready)
    );

    fifo_id_stage u_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .flush_cause (flush_cause),
        .q_valid     (q_valid),
        .q_pkt       (q_pkt),
        .id_allowin  (id_allowin),
        .q_ready     (q_ready),
        .stage_valid (stage_valid),
        .stage_pkt   (stage_pkt)
    );

    // one decoder per instruction of the packet
    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_dec
        logic [31:0] inst_sel;

        assign inst_sel = (i == 0) ? stage_pkt.inst0 : stage_pkt.inst1;

        slot_decoder u_dec (
            .inst (inst_sel),
            .slot (dec_slots[i])
        );
    end

    id_bundle u_bundle (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .stage_valid (stage_valid),
        .stage_pkt   (stage_pkt),
        .slots       (dec_slots),
        .id_allowin  (id_allowin),
        .id_valid    (id_valid),
        .id_bundle   (id_bundle)
    );

endmodule

/* verif/frontend_asserts.sv */
`timescale 1ns/1ns
`include "fe_consts.svh"

module frontend_asserts
    import dec_pkg::*;
(
    input logic          clk,
    input logic          arst_n,
    input logic          flush,
    input logic          fetch_valid,
    input logic          fetch_ready,
    input logic          q_valid,
    input logic          q_ready,
    input logic          id_allowin,
    input logic          id_valid,
    input issue_bundle_t id_bundle
);

    int held;   // queue occupancy, rebuilt from the push and pop handshakes

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            held <= 0;
        else if (flush)
            held <= 0;
        else
            held <= held + int'(fetch_valid && fetch_ready) - int'(q_valid && q_ready);
    end

    a_reset_idle: assert property (@(posedge clk)
        (!arst_n || $rose(arst_n)) |-> !id_valid)
        else $error("id_valid high in or right after reset");

    // issue side may sample the bundle any time while it waits
    a_hold_stall: assert property (@(posedge clk) disable iff (!arst_n)
        (id_valid && !id_allowin && !flush) |=> $stable(id_bundle))
        else $error("bundle changed while the issue side stalled");

    a_full_stops_fetch: assert property (@(posedge clk) disable iff (!arst_n)
        (held == `IQ_DEPTH) |-> !fetch_ready)
        else $error("fetch_ready high with %0d packets queued", held);

endmodule

bind frontend_top frontend_asserts u_asserts (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (flush),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .q_valid     (q_valid),
    .q_ready     (q_ready),
    .id_allowin  (id_allowin),
    .id_valid    (id_valid),
    .id_bundle   (id_bundle)
);

/* verif/tb_frontend.sv */
`timescale 1ns/1ns

module tb_frontend
    import fe_pkg::*;
    import dec_pkg::*;
();

    typedef struct packed {
        logic [127:0] name;
        logic         valid;
        logic [31:0]  inst0;
        logic [31:0]  inst1;
        logic [31:0]  pc;
        logic         flush;
        logic [7:0]   allow;     // "0", "1" or "r"
        logic [7:0]   ready;     // expected fetch_ready, "-" when not looked at
        logic         check;
        logic [2:0]   op0;
        logic [2:0]   op1;
        logic         pair_ok;
        logic [31:0]  exp_pc;
    } step_t;

    typedef struct packed {
        logic [127:0] name;
        logic [2:0]   op0;
        logic [2:0]   op1;
        logic         pair_ok;
        logic [31:0]  pc;
        logic [31:0]  imm0;
        logic [31:0]  imm1;
        logic [6:0]   exception;
        logic [1:0]   excp_flag;
    } expect_t;

    logic          clk;
    logic          arst_n;
    logic          flush;
    flush_cause_e  flush_cause;
    logic          fetch_valid;
    fetch_pkt_t    fetch_pkt;
    logic          fetch_ready;
    logic          id_allowin;
    logic          id_valid;
    issue_bundle_t id_bundle;

    step_t   steps [$];
    expect_t exp_q [$];     // bundles still owed, in push order
    expect_t head;
    int      errors;
    int      cycles;
    int      limit;

    frontend_top u_frontend_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .flush_cause (flush_cause),
        .fetch_valid (fetch_valid),
        .fetch_pkt   (fetch_pkt),
        .fetch_ready (fetch_ready),
        .id_allowin  (id_allowin),
        .id_valid    (id_valid),
        .id_bundle   (id_bundle)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, %0d bundles never came out", cycles, exp_q.size());
            $display("** FAIL **");
            $finish;
        end
    end

    // a bundle counts once, on the edge that hands it to the issue side
    always @(negedge clk) begin
        if (arst_n && id_valid && id_allowin && !flush) begin
            if (exp_q.size() == 0) begin
                $display("extra bundle with pc %h came out, none was expected", id_bundle.pc);
                errors++;
            end else begin
                head = exp_q.pop_front();
                if (id_bundle.slot0.op !== head.op0) begin
                    $display("FAIL %0s slot0.op expected %0d actual %0d",
                             head.name, head.op0, id_bundle.slot0.op);
                    errors++;
                end
                if (id_bundle.slot1.op !== head.op1) begin
                    $display("FAIL %0s slot1.op expected %0d actual %0d",
                             head.name, head.op1, id_bundle.slot1.op);
                    errors++;
                end
                if (id_bundle.pair_ok !== head.pair_ok) begin
                    $display("FAIL %0s pair_ok expected %b actual %b",
                             head.name, head.pair_ok, id_bundle.pair_ok);
                    errors++;
                end
                if (id_bundle.pc !== head.pc) begin
                    $display("FAIL %0s pc expected %h actual %h", head.name, head.pc, id_bundle.pc);
                    errors++;
                end
                if (id_bundle.slot0.imm !== head.imm0) begin
                    $display("FAIL %0s slot0.imm expected %h actual %h",
                             head.name, head.imm0, id_bundle.slot0.imm);
                    errors++;
                end
                if (id_bundle.slot1.imm !== head.imm1) begin
                    $display("FAIL %0s slot1.imm expected %h actual %h",
                             head.name, head.imm1, id_bundle.slot1.imm);
                    errors++;
                end
                if (id_bundle.exception !== head.exception) begin
                    $display("FAIL %0s exception expected %h actual %h",
                             head.name, head.exception, id_bundle.exception);
                    errors++;
                end
                if (id_bundle.excp_flag !== head.excp_flag) begin
                    $display("FAIL %0s excp_flag expected %b actual %b",
                             head.name, head.excp_flag, id_bundle.excp_flag);
                    errors++;
                end
            end
        end
    end

    function automatic logic pick_allowin(input logic [7:0] mode);
        if (mode == "r")
            return ($urandom % 4) != 0;     // stall about one cycle in four
        return mode == "1";
    endfunction

    // 12-bit immediate field at bits 21..10, sign-extended
    function automatic logic [31:0] imm_of(input logic [31:0] inst);
        logic signed [11:0] field;
        field = inst[21:10];
        return 32'(field);
    endfunction

    task automatic load_golden();
        int           fd;
        int           n;
        string        line;
        step_t        s;
        logic [127:0] name;
        int           v;
        int           fl;
        int           chk;
        int           op0;
        int           op1;
        int           pr;
        logic [31:0]  i0;
        logic [31:0]  i1;
        logic [31:0]  pc;
        logic [31:0]  epc;
        logic [7:0]   al;
        logic [7:0]   rd;
        fd = $fopen("verif/frontend_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/frontend_golden.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %d %h %h %h %d %s %s %d %d %d %d %h",
                                name, v, i0, i1, pc, fl, al, rd, chk, op0, op1, pr, epc);
                    if (n == 13) begin
                        s.name    = name;
                        s.valid   = v[0];
                        s.inst0   = i0;
                        s.inst1   = i1;
                        s.pc      = pc;
                        s.flush   = fl[0];
                        s.allow   = al;
                        s.ready   = rd;
                        s.check   = chk[0];
                        s.op0     = op0[2:0];
                        s.op1     = op1[2:0];
                        s.pair_ok = pr[0];
                        s.exp_pc  = epc;
                        steps.push_back(s);
                    end else begin
                        $display("golden line not understood: %0s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_step(input step_t s);
        fetch_pkt_t pkt;
        pkt           = '0;
        pkt.inst0     = s.inst0;
        pkt.inst1     = s.inst1;
        pkt.pc        = s.pc;
        pkt.pc_add    = s.pc + 32'd4;
        pkt.pc_next   = s.pc + 32'd8;
        pkt.exception = s.pc[10:4];         // exception fields follow the pc
        pkt.excp_flag = s.pc[5:4];
        @(posedge clk);
        fetch_valid <= s.valid;
        fetch_pkt   <= pkt;
        flush       <= s.flush;
        flush_cause <= s.flush ? branch : none;
        id_allowin  <= pick_allowin(s.allow);
        @(negedge clk);
        if (s.ready != "-" && fetch_ready !== (s.ready == "1")) begin
            $display("FAIL %0s fetch_ready expected %0s actual %b", s.name, s.ready, fetch_ready);
            errors++;
        end
        while (s.valid && !fetch_ready) begin
            @(posedge clk);                         // queue full, keep offering
            id_allowin <= pick_allowin(s.allow);
            @(negedge clk);
        end
        if (s.valid && s.check)
            exp_q.push_back(expect_t'{name: s.name, op0: s.op0, op1: s.op1,
                                      pair_ok: s.pair_ok, pc: s.exp_pc,
                                      imm0: imm_of(s.inst0), imm1: imm_of(s.inst1),
                                      exception: pkt.exception,
                                      excp_flag: pkt.excp_flag});
        // idle step with a check waits for every bundle still owed
        if (!s.valid && s.check) begin
            while (exp_q.size() != 0)
                @(negedge clk);
        end
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        flush       = 1'b0;
        flush_cause = none;
        fetch_valid = 1'b0;
        fetch_pkt   = '0;
        id_allowin  = 1'b0;
        errors      = 0;
        cycles      = 0;
        limit       = 0;
        void'($urandom(32'hce49_bb33));
        load_golden();
        if (steps.size() == 0) begin
            $display("no steps were read from the golden file");
            errors++;
        end
        limit = steps.size() * 4 + 20;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        if (id_valid !== 1'b0) begin
            $display("id_valid is not low after reset");
            errors++;
        end
        foreach (steps[k])
            run_step(steps[k]);
        @(posedge clk);
        fetch_valid <= 1'b0;
        flush       <= 1'b0;
        flush_cause <= none;
        id_allowin  <= 1'b1;
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);      // room for a stray extra bundle
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* all.f */
+incdir+include
source/fe_pkg.sv
source/dec_pkg.sv
source/inst_queue.sv
source/fifo_id_stage.sv
source/slot_decoder.sv
source/id_bundle.sv
source/frontend_top.sv
verif/frontend_asserts.sv
verif/tb_frontend.sv

/* verif/frontend_golden.txt */
# name valid inst0 inst1 pc flush allowin(0,1,r) fetch_ready(0,1,-) check op0 op1 pair_ok exp_pc
# ops 0 nop 1 alu_rr 2 alu_ri 3 load 4 store 5 branch 6 invalid, check on idle step waits for all
reset       0 03400000 03400000 00000000 0 1 1 0 0 0 0 00000000
first       1 04000c41 080000a4 1c000100 0 1 1 1 1 2 1 1c000100
ops_ld_st   1 0c0000e6 10000128 1c000110 0 1 - 1 3 4 1 1c000110
ops_alu_br  1 0800016a 14003580 1c000120 0 1 - 1 2 5 1 1c000120
ops_nop_inv 1 03400000 fc000000 1c000130 0 1 - 1 0 6 1 1c000130
ops_inv_nop 1 fc000000 03400000 1c000140 0 1 - 1 6 0 0 1c000140
pair_raw_rj 1 04000825 080000a6 1c000200 0 1 - 1 1 2 0 1c000200
pair_raw_rk 1 0c000027 04001c48 1c000210 0 1 - 1 3 1 0 1c000210
pair_waw    1 08000029 0c000049 1c000220 0 1 - 1 2 3 0 1c000220
pair_br0    1 14000820 04001483 1c000230 0 1 - 1 5 1 0 1c000230
pair_rd0    1 04000820 04000000 1c000240 0 1 - 1 1 1 1 1c000240
st_a        1 08000041 10000083 1c000400 0 1 - 1 2 4 1 1c000400
st_b        1 08000041 10000083 1c000410 0 1 - 1 2 4 1 1c000410
st_c        1 08000041 10000083 1c000420 0 1 - 1 2 4 1 1c000420
st_d        1 08000041 10000083 1c000430 0 0 - 1 2 4 1 1c000430
st_e        1 08000041 10000083 1c000440 0 0 - 1 2 4 1 1c000440
st_f        1 08000041 10000083 1c000450 0 0 - 1 2 4 1 1c000450
st_g        1 08000041 10000083 1c000460 0 0 - 1 2 4 1 1c000460
st_h        1 08000041 10000083 1c000470 0 0 - 1 2 4 1 1c000470
st_i        1 08000041 10000083 1c000480 0 0 - 1 2 4 1 1c000480
st_j        1 08000041 10000083 1c000490 0 0 1 1 2 4 1 1c000490
st_full     0 03400000 03400000 00000000 0 0 0 0 0 0 0 00000000
rnd_0       1 0c0000c5 04002507 1c000500 0 r - 1 3 1 1 1c000500
rnd_1       1 0c0000c5 040024a7 1c000510 0 r - 1 3 1 0 1c000510
rnd_2       1 0c0000c5 04002507 1c000520 0 r - 1 3 1 1 1c000520
drain       0 03400000 03400000 00000000 0 1 - 1 0 0 0 00000000
fl_old0     1 08000041 10000083 1c000800 0 0 - 0 2 4 1 1c000800
fl_old1     1 08000041 10000083 1c000810 0 1 - 0 2 4 1 1c000810
fl_old2     1 08000041 10000083 1c000820 0 0 - 0 2 4 1 1c000820
flush       0 03400000 03400000 00000000 1 1 - 0 0 0 0 00000000
fl_new0     1 04000c41 14003580 1c000900 0 1 - 1 1 5 1 1c000900
fl_new1     1 14000820 03400000 1c000910 0 1 - 1 5 0 0 1c000910
